// File: hw/axi_write_master.sv
// AXI4 write master, carries one burst through AW, W and B and pops the FIFO per beat
`timescale 1ns/100ps
`default_nettype none

module axi_write_master import vdma_write_pkg::*; (
    input  logic       clock,
    input  logic       rst,
    input  logic       req_valid,
    input  burst_req_t req,
    output logic       req_accept,
    output logic       req_done,
    input  logic       empty,
    output logic       rd_en,
    output addr_t      awaddr,
    output logic [7:0] awlen,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    output logic       awvalid,
    input  logic       awready,
    output logic       wvalid,
    input  logic       wready,
    output logic       wlast,
    output logic       bready,
    input  logic       bvalid
);

    master_state_t state;
    // beats accepted so far in this burst
    logic [7:0]    beat_cnt;
    // W handshake this cycle
    logic          w_fire;

    // 16-byte beats, INCR bursts
    assign awsize  = 3'($clog2(WORD_BYTES));
    assign awburst = 2'b01;

    assign req_accept = (state == IDLE) && req_valid;
    assign awvalid    = (state == ADDR);
    // data only offered when the FIFO head is real
    assign wvalid     = (state == DATA) && !empty;
    assign wlast      = (state == DATA) && (beat_cnt == awlen);
    assign bready     = (state == RESP);
    assign w_fire     = wvalid && wready;
    // one pop per accepted beat
    assign rd_en      = w_fire;

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= IDLE;
            beat_cnt <= '0;
            req_done <= 1'b0;
        end else begin
            req_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    beat_cnt <= '0;
                    if (awready) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (w_fire) begin
                        if (wlast) begin
                            state <= RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                RESP: begin
                    // bresp not checked
                    if (bvalid) begin
                        state    <= IDLE;
                        req_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // AW payload captured on accept
    always_ff @(posedge clock) begin
        if (req_accept) begin
            awaddr <= req.addr;
            awlen  <= 8'(req.len - 1'b1);
        end
    end

    // AW must not change while the slave stalls it
    a_aw_stable: assert property (@(posedge clock) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen));

    // scheduler never asks for an empty burst
    a_req_len: assert property (@(posedge clock) disable iff (rst)
        req_valid |-> req.len != '0);

endmodule

`default_nettype wire

// File: hw/burst_scheduler.sv
// splits each video line into fixed bursts plus a tail and hands out one request at a time
`timescale 1ns/100ps
`default_nettype none

module burst_scheduler import vdma_write_pkg::*; #(
    parameter int BURST_LEN   = 8,
    parameter int LINE_STRIDE = 4096
) (
    input  logic       clock,
    input  logic       rst,
    input  logic       frame_start,
    input  addr_t      baseaddr,
    input  dim_t       hactive,
    input  level_t     level,
    output logic       req_valid,
    output burst_req_t req,
    input  logic       req_accept,
    input  logic       req_done
);

    // hactive plus rounding in one bit more than dim_t
    logic [16:0] hactive_up;
    // words in one line
    dim_t        words_per_line;
    // words of the current line not yet requested
    dim_t        words_left;
    // start of current line and address of the next burst
    addr_t       line_start;
    addr_t       next_addr;
    // length of the next request
    blen_t       next_len;
    // burst taken by the master and waiting for its response
    logic        busy;
    logic        can_issue;

    assign hactive_up     = {1'b0, hactive} + 17'(PIXELS_PER_WORD - 1);
    assign words_per_line = dim_t'(hactive_up / 17'(PIXELS_PER_WORD));

    // full burst while the line allows, else the tail
    assign next_len = (words_left >= dim_t'(BURST_LEN)) ? blen_t'(BURST_LEN)
                                                       : blen_t'(words_left);

    // only raise once the FIFO holds the whole burst
    assign can_issue = !req_valid && !busy && (words_left != '0) &&
                       (blen_t'(level) >= next_len);

    // line bookkeeping steps when the master takes a request
    always_ff @(posedge clock) begin
        if (rst) begin
            words_left <= '0;
            line_start <= '0;
            next_addr  <= '0;
        end else if (frame_start) begin
            // new base and line index back to zero
            words_left <= words_per_line;
            line_start <= baseaddr;
            next_addr  <= baseaddr;
        end else if (req_accept) begin
            if (words_left == dim_t'(req.len)) begin
                // line done so jump to the next line start
                words_left <= words_per_line;
                line_start <= line_start + addr_t'(LINE_STRIDE);
                next_addr  <= line_start + addr_t'(LINE_STRIDE);
            end else begin
                words_left <= words_left - dim_t'(req.len);
                next_addr  <= next_addr + addr_t'(req.len) * addr_t'(WORD_BYTES);
            end
        end
    end

    // request handshake with one burst in flight
    always_ff @(posedge clock) begin
        if (rst) begin
            req_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            if (req_accept) begin
                req_valid <= 1'b0;
                busy      <= 1'b1;
            end else if (can_issue) begin
                req_valid <= 1'b1;
            end
            if (req_done) begin
                busy <= 1'b0;
            end
        end
    end

    // payload tracks the counters until it is offered
    always_ff @(posedge clock) begin
        if (!req_valid) begin
            req.addr <= next_addr;
            req.len  <= next_len;
        end
    end

    // a response only closes a burst that was handed out
    a_done_in_flight: assert property (@(posedge clock) disable iff (rst)
        req_done |-> busy);

endmodule

`default_nettype wire

// File: hw/pixel_packer.sv
// packs 24-bit pixels four to a 128-bit word and flushes a short word at each line end
`timescale 1ns/100ps
`default_nettype none

module pixel_packer import vdma_write_pkg::*; (
    input  logic        clock,
    input  logic        rst,
    input  video_beat_t beat,
    output logic        wr_en,
    output word_t       wr_word
);

    // slot width and slot index width
    localparam int SLOT_W   = $bits(word_t) / PIXELS_PER_WORD;
    localparam int SLOT_IDX = $clog2(PIXELS_PER_WORD);

    // next free slot of the word being built
    logic [SLOT_IDX-1:0] slot;
    // pixels gathered so far in this word
    word_t               acc;
    // acc with the incoming pixel dropped in
    word_t               filled;

    // slot 0 starts a clean word, so unused slots stay zero
    always_comb begin
        filled = (slot == '0) ? '0 : acc;
        // upper 8 bits of the slot zero extended
        filled[slot*SLOT_W +: SLOT_W] = SLOT_W'(beat.pixel);
    end

    // slot counter and write strobe
    always_ff @(posedge clock) begin
        if (rst) begin
            slot  <= '0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (beat.valid) begin
                if (slot == SLOT_IDX'(PIXELS_PER_WORD - 1)) begin
                    // word full, push it
                    wr_en <= 1'b1;
                    slot  <= '0;
                end else begin
                    slot  <= slot + 1'b1;
                end
            end else if (beat.line_end && slot != '0) begin
                // partial word at end of line
                wr_en <= 1'b1;
                slot  <= '0;
            end
        end
    end

    // word data path
    always_ff @(posedge clock) begin
        if (beat.valid) begin
            acc     <= filled;
            wr_word <= filled;
        end else if (beat.line_end) begin
            wr_word <= acc;
        end
    end

    // every line leaves the packer on a word boundary
    a_slot_clear: assert property (@(posedge clock) disable iff (rst)
        beat.line_end |=> slot == '0);

endmodule

`default_nettype wire

// File: hw/stream_fifo.sv
// synchronous word FIFO between packer and AXI master, head word visible without a read cycle
`timescale 1ns/100ps
`default_nettype none

module stream_fifo import vdma_write_pkg::*; #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic   clock,
    input  logic   rst,
    input  logic   wr_en,
    input  word_t  wr_word,
    input  logic   rd_en,
    output word_t  rd_word,
    output logic   empty,
    output level_t level,
    output logic   almost_full
);

    localparam int               PTR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);

    // storage
    word_t            mem [FIFO_DEPTH];
    // write and read positions
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // pointers wrap at the last entry, depth need not be a power of two
    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // level moves only when one side is active
            case ({wr_en, rd_en})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // head of queue straight to wdata
    assign rd_word     = mem[rd_ptr];
    assign empty       = (level == '0);
    // leaves 4 words of slack for the packer
    assign almost_full = (level >= level_t'(FIFO_DEPTH - 4));

    // packer has no back-pressure, it must never hit a full FIFO
    a_no_overflow: assert property (@(posedge clock) disable iff (rst)
        wr_en |-> level != level_t'(FIFO_DEPTH));

    // master pops only on data that is already stored
    a_no_underflow: assert property (@(posedge clock) disable iff (rst)
        rd_en |-> !empty);

endmodule

`default_nettype wire

// File: hw/vdma_write.sv
// video write DMA top, native video in and AXI4 write bursts out, one line per stride
`timescale 1ns/100ps
`default_nettype none

module vdma_write import vdma_write_pkg::*; #(
    parameter int BURST_LEN   = 8,
    parameter int LINE_STRIDE = 4096,
    parameter int FIFO_DEPTH  = 64
) (
    input  logic       clock,
    input  logic       rst,
    input  logic       vsync,
    input  logic       de,
    input  pixel_t     idata,
    input  dim_t       hactive,
    input  addr_t      baseaddr,
    output logic       fifo_almost_full,
    output addr_t      awaddr,
    output logic [7:0] awlen,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    output logic       awvalid,
    input  logic       awready,
    output word_t      wdata,
    output logic       wvalid,
    input  logic       wready,
    output logic       wlast,
    output logic       bready,
    input  logic       bvalid
);

    // in-port to packer
    video_beat_t beat;
    logic        frame_start;
    // packer to FIFO
    logic        wr_en;
    word_t       wr_word;
    // FIFO status and pop
    logic        rd_en;
    logic        empty;
    level_t      level;
    // scheduler to master
    logic        req_valid;
    burst_req_t  req;
    logic        req_accept;
    logic        req_done;

    video_in_port u_video_in_port (
        .clock       (clock),
        .rst         (rst),
        .vsync       (vsync),
        .de          (de),
        .idata       (idata),
        .beat        (beat),
        .frame_start (frame_start)
    );

    pixel_packer u_pixel_packer (
        .clock   (clock),
        .rst     (rst),
        .beat    (beat),
        .wr_en   (wr_en),
        .wr_word (wr_word)
    );

    // FIFO head goes straight out as wdata
    stream_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_stream_fifo (
        .clock       (clock),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_word     (wr_word),
        .rd_en       (rd_en),
        .rd_word     (wdata),
        .empty       (empty),
        .level       (level),
        .almost_full (fifo_almost_full)
    );

    burst_scheduler #(
        .BURST_LEN   (BURST_LEN),
        .LINE_STRIDE (LINE_STRIDE)
    ) u_burst_scheduler (
        .clock       (clock),
        .rst         (rst),
        .frame_start (frame_start),
        .baseaddr    (baseaddr),
        .hactive     (hactive),
        .level       (level),
        .req_valid   (req_valid),
        .req         (req),
        .req_accept  (req_accept),
        .req_done    (req_done)
    );

    axi_write_master u_axi_write_master (
        .clock      (clock),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_accept (req_accept),
        .req_done   (req_done),
        .empty      (empty),
        .rd_en      (rd_en),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awsize     (awsize),
        .awburst    (awburst),
        .awvalid    (awvalid),
        .awready    (awready),
        .wvalid     (wvalid),
        .wready     (wready),
        .wlast      (wlast),
        .bready     (bready),
        .bvalid     (bvalid)
    );

endmodule

`default_nettype wire

// File: hw/vdma_write_pkg.sv
// shared widths, payload structs and FSM states for the video write DMA, imported by all RTL
`default_nettype none

package vdma_write_pkg;

    // one video pixel, rgb 8:8:8
    typedef logic [23:0]  pixel_t;
    // one AXI data beat, four pixels in 32-bit slots
    typedef logic [127:0] word_t;
    // byte address
    typedef logic [31:0]  addr_t;
    // burst length in words, 256 must fit
    typedef logic [8:0]   blen_t;
    // FIFO fill level in words
    typedef logic [7:0]   level_t;
    // video size in pixels
    typedef logic [15:0]  dim_t;

    // pixels packed into each word
    localparam int PIXELS_PER_WORD = 4;
    // bytes per word, sets address step and awsize
    localparam int WORD_BYTES      = 16;

    // one burst request, len counted in words and never zero
    typedef struct packed {
        addr_t addr;
        blen_t len;
    } burst_req_t;

    // registered video beat, line_end pulses after the last pixel
    typedef struct packed {
        logic   valid;
        logic   line_end;
        pixel_t pixel;
    } video_beat_t;

    // write master walks AW, W and B for a single burst
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } master_state_t;

endpackage

`default_nettype wire

// File: hw/video_in_port.sv
// input register stage for native video, turns vsync and de edges into frame and line strobes
`timescale 1ns/100ps
`default_nettype none

module video_in_port import vdma_write_pkg::*; (
    input  logic        clock,
    input  logic        rst,
    input  logic        vsync,
    input  logic        de,
    input  pixel_t      idata,
    output video_beat_t beat,
    output logic        frame_start
);

    // vsync one cycle back for edge detect
    logic vsync_q;

    always_ff @(posedge clock) begin
        // pixel just follows the input by a cycle
        beat.pixel <= idata;
        if (rst) begin
            beat.valid    <= 1'b0;
            beat.line_end <= 1'b0;
            vsync_q       <= 1'b0;
            frame_start   <= 1'b0;
        end else begin
            beat.valid    <= de;
            // de just fell while the last pixel is still held in beat
            beat.line_end <= beat.valid & ~de;
            vsync_q       <= vsync;
            // rising vsync opens a new frame
            frame_start   <= vsync & ~vsync_q;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in its output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vdma_write -f vdma_write.f

out=$(./obj_dir/Vtb_vdma_write 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "All tests passed!"

// File: vdma_write.f
hw/vdma_write_pkg.sv
hw/video_in_port.sv
hw/pixel_packer.sv
hw/stream_fifo.sv
hw/burst_scheduler.sv
hw/axi_write_master.sv
hw/vdma_write.sv
verification/tb_clock_gen.sv
verification/tb_vdma_write.sv

// File: verification/tb_clock_gen.sv
// clock and reset source for the testbench, free running clock with a short reset at start
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic rst
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // reset seen high on the first RESET_CYCLES rising edges
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/tb_vdma_write.sv
// self-checking testbench for the video write DMA, sends video frames into a simple AXI slave
`timescale 1ns/100ps
`default_nettype none

module tb_vdma_write import vdma_write_pkg::*; ();

    localparam int BURST_LEN   = 8;
    localparam int LINE_STRIDE = 4096;
    localparam int FIFO_DEPTH  = 64;
    // lines per frame and idle cycles between lines
    localparam int N_LINES  = 4;
    localparam int LINE_GAP = 16;
    // stalled frame of 10-word lines fills the FIFO up to the almost-full mark
    localparam int FILL_LINES = (FIFO_DEPTH - 4) / 10;
    // three frames of 10, 10 and 7 words per line plus the stalled frame
    localparam int TOTAL_BEATS     = N_LINES * (10 + 10 + 7) + FILL_LINES * 10;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 1000;

    logic       clock;
    logic       rst;
    logic       vsync;
    logic       de;
    pixel_t     idata;
    dim_t       hactive;
    addr_t      baseaddr;
    logic       fifo_almost_full;
    addr_t      awaddr;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic       awvalid;
    logic       awready;
    word_t      wdata;
    logic       wvalid;
    logic       wready;
    logic       wlast;
    logic       bready;
    logic       bvalid;

    // expected words and bursts in order
    word_t       word_q[$];
    burst_req_t  burst_q[$];
    // model outputs for the coming edge are written at negedge
    word_t       exp_word    = '0;
    burst_req_t  exp_burst   = '0;
    logic        exp_last    = 1'b0;
    logic        extra_word  = 1'b0;
    logic        extra_burst = 1'b0;
    int          cur_len      = 0;
    int          beats_done   = 0;
    int          words_pushed = 0;
    // words stored in the FIFO as seen from the video and W sides
    int          fifo_level = 0;
    int          pix_cnt    = 0;
    logic [2:0]  push_pipe  = '0;
    logic        pop_prev   = 1'b0;
    logic        de_prev    = 1'b0;
    // slave response and back-pressure control
    logic        resp_due = 1'b0;
    logic        b_done   = 1'b0;
    logic        bp_on    = 1'b0;
    logic        aw_stall = 1'b0;
    logic [31:0] lfsr     = 32'hfc68903f;
    // bookkeeping
    string       test_name    = "none";
    int          err_count    = 0;
    int          err_at_start = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (3)
    ) u_clock_gen (
        .clock (clock),
        .rst   (rst)
    );

    vdma_write #(
        .BURST_LEN   (BURST_LEN),
        .LINE_STRIDE (LINE_STRIDE),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_vdma_write (
        .clock            (clock),
        .rst              (rst),
        .vsync            (vsync),
        .de               (de),
        .idata            (idata),
        .hactive          (hactive),
        .baseaddr         (baseaddr),
        .fifo_almost_full (fifo_almost_full),
        .awaddr           (awaddr),
        .awlen            (awlen),
        .awsize           (awsize),
        .awburst          (awburst),
        .awvalid          (awvalid),
        .awready          (awready),
        .wdata            (wdata),
        .wvalid           (wvalid),
        .wready           (wready),
        .wlast            (wlast),
        .bready           (bready),
        .bvalid           (bvalid)
    );

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // model side of the bus settles half a cycle after the edge
    always @(negedge clock) begin
        extra_word  = 1'b0;
        extra_burst = 1'b0;
        if (!rst) begin
            if (awvalid && awready) begin
                if (burst_q.size() == 0) begin
                    extra_burst = 1'b1;
                end else begin
                    exp_burst  = burst_q.pop_front();
                    cur_len    = int'(exp_burst.len);
                    beats_done = 0;
                end
            end
            if (wvalid && wready) begin
                if (word_q.size() == 0) begin
                    extra_word = 1'b1;
                end else begin
                    exp_word = word_q.pop_front();
                end
                exp_last = (beats_done == cur_len - 1);
                beats_done++;
                // slave answers once the burst is in
                if (wlast) begin
                    resp_due = 1'b1;
                end
            end
            if (bvalid && bready) begin
                b_done = 1'b1;
            end
        end
    end

    // a word is stored three edges after its fourth pixel or its line end
    always @(negedge clock) begin
        logic push;
        push = 1'b0;
        if (rst) begin
            fifo_level = 0;
            pix_cnt    = 0;
            push_pipe  = '0;
            pop_prev   = 1'b0;
            de_prev    = 1'b0;
        end else begin
            fifo_level = fifo_level + int'(push_pipe[2]) - int'(pop_prev);
            if (de) begin
                pix_cnt++;
                if (pix_cnt == 4) begin
                    push    = 1'b1;
                    pix_cnt = 0;
                end
            end else if (de_prev && pix_cnt != 0) begin
                // short word flushed at line end
                push    = 1'b1;
                pix_cnt = 0;
            end
            push_pipe = {push_pipe[1:0], push};
            // a W beat leaves the FIFO on the next edge
            pop_prev  = wvalid && wready;
            de_prev   = de;
        end
    end

    // nothing on the bus before a full first burst has been fed in
    a_reset_quiet: assert property (@(posedge clock)
        words_pushed < BURST_LEN |-> !awvalid && !wvalid && !bready)
        else begin
            err_count++;
            $display("FAILED %s reset quiet: expected 000, actual %b%b%b", test_name,
                     $sampled(awvalid), $sampled(wvalid), $sampled(bready));
        end

    a_wdata: assert property (@(posedge clock) disable iff (rst)
        wvalid && wready && !extra_word |-> wdata == exp_word)
        else begin
            err_count++;
            $display("FAILED %s wdata: expected %h, actual %h", test_name, exp_word,
                     $sampled(wdata));
        end

    a_extra_word: assert property (@(posedge clock) disable iff (rst) !extra_word)
        else begin
            err_count++;
            $display("%s: a W beat was accepted with no word left to send", test_name);
        end

    a_awaddr: assert property (@(posedge clock) disable iff (rst)
        awvalid && awready && !extra_burst |-> awaddr == exp_burst.addr)
        else begin
            err_count++;
            $display("FAILED %s awaddr: expected %h, actual %h", test_name, exp_burst.addr,
                     $sampled(awaddr));
        end

    a_awlen: assert property (@(posedge clock) disable iff (rst)
        awvalid && awready && !extra_burst |-> awlen == 8'(exp_burst.len - 9'd1))
        else begin
            err_count++;
            $display("FAILED %s awlen: expected %0d, actual %0d", test_name,
                     exp_burst.len - 9'd1, $sampled(awlen));
        end

    a_extra_burst: assert property (@(posedge clock) disable iff (rst) !extra_burst)
        else begin
            err_count++;
            $display("%s: an address was accepted with no burst left to write", test_name);
        end

    // wlast on the final beat and nowhere else
    a_wlast: assert property (@(posedge clock) disable iff (rst)
        wvalid && wready |-> wlast == exp_last)
        else begin
            err_count++;
            $display("FAILED %s wlast: expected %b, actual %b", test_name, exp_last,
                     $sampled(wlast));
        end

    // 16-byte beats in INCR bursts
    a_aw_fixed: assert property (@(posedge clock) disable iff (rst)
        awvalid |-> awsize == 3'd4 && awburst == 2'b01)
        else begin
            err_count++;
            $display("FAILED %s awsize/awburst: expected 4/1, actual %0d/%0d", test_name,
                     $sampled(awsize), $sampled(awburst));
        end

    // almost full once FIFO_DEPTH-4 or more words are stored
    a_almost_full: assert property (@(posedge clock) disable iff (rst)
        fifo_almost_full == (fifo_level >= FIFO_DEPTH - 4))
        else begin
            err_count++;
            $display("FAILED %s almost_full: expected %b, actual %b", test_name,
                     fifo_level >= FIFO_DEPTH - 4, $sampled(fifo_almost_full));
        end

    a_aw_hold: assert property (@(posedge clock) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
        else begin
            err_count++;
            $display("%s: address channel changed while the slave stalled it", test_name);
        end

    a_w_hold: assert property (@(posedge clock) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else begin
            err_count++;
            $display("%s: write data changed while the slave stalled it", test_name);
        end

    // all inputs move 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #2;
        if (bp_on) begin
            // ready low one time in four
            awready = (rand_bits(2) != 0);
            wready  = (rand_bits(2) != 0);
        end else begin
            awready = 1'b1;
            wready  = 1'b1;
        end
        // held address channel lets the FIFO fill up
        if (aw_stall) begin
            awready = 1'b0;
        end
        if (b_done) begin
            bvalid = 1'b0;
            b_done = 1'b0;
        end
        if (resp_due) begin
            bvalid   = 1'b1;
            resp_due = 1'b0;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    // expected bursts of one line are full bursts then the tail
    task automatic plan_line(input addr_t base, input int ln, input int words);
        burst_req_t b;
        addr_t      a;
        int         left;
        a    = base + addr_t'(ln * LINE_STRIDE);
        left = words;
        while (left > 0) begin
            b.addr = a;
            b.len  = (left >= BURST_LEN) ? 9'(BURST_LEN) : 9'(left);
            burst_q.push_back(b);
            a    = a + addr_t'(b.len) * 32'd16;
            left = left - int'(b.len);
        end
    endtask

    task automatic send_line(input int npix);
        word_t w;
        int    slot;
        w    = '0;
        slot = 0;
        for (int i = 0; i < npix; i++) begin
            next_cycle();
            de    = 1'b1;
            idata = pixel_t'(rand_bits(24));
            // pixel in low 24 bits of its 32-bit slot
            w[slot*32 +: 32] = {8'h00, idata};
            slot++;
            if (slot == 4) begin
                word_q.push_back(w);
                words_pushed++;
                w    = '0;
                slot = 0;
            end
        end
        // short last word keeps its empty slots at zero
        if (slot != 0) begin
            word_q.push_back(w);
            words_pushed++;
        end
        next_cycle();
        de = 1'b0;
    endtask

    // done once every burst is written and answered
    task automatic wait_drain();
        while (word_q.size() != 0 || burst_q.size() != 0 || bready || bvalid || resp_due) begin
            next_cycle();
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        err_at_start = err_count;
        tests_run++;
    endtask

    task automatic end_test();
        int errs;
        errs = err_count - err_at_start;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %-16s %s, %0d errors", test_name, (errs == 0) ? "ok" : "FAIL", errs);
    endtask

    // vsync opens the frame with a new base before its lines
    task automatic run_frame(input string name, input addr_t base, input int npix,
                             input int nlines, input logic bp, input logic hold_aw);
        int words;
        begin_test(name);
        words    = (npix + 3) / 4;
        bp_on    = bp;
        aw_stall = hold_aw;
        next_cycle();
        hactive  = dim_t'(npix);
        baseaddr = base;
        vsync    = 1'b1;
        idle(2);
        vsync = 1'b0;
        idle(4);
        for (int ln = 0; ln < nlines; ln++) begin
            plan_line(base, ln, words);
            send_line(npix);
            idle(LINE_GAP);
        end
        // release the held address channel and let the FIFO drain
        aw_stall = 1'b0;
        wait_drain();
        bp_on = 1'b0;
        idle(4);
        end_test();
    endtask

    initial begin
        vsync    = 1'b0;
        de       = 1'b0;
        idata    = '0;
        hactive  = dim_t'(40);
        baseaddr = '0;
        awready  = 1'b1;
        wready   = 1'b1;
        bvalid   = 1'b0;

        begin_test("reset");
        while (rst) begin
            next_cycle();
        end
        idle(10);
        end_test();

        run_frame("frame_40px", 32'h1000_0000, 40, N_LINES, 1'b0, 1'b0);
        run_frame("backpressure", 32'h2000_0000, 40, N_LINES, 1'b1, 1'b0);
        run_frame("new_frame_26px", 32'h3000_8000, 26, N_LINES, 1'b1, 1'b0);
        run_frame("fifo_fill", 32'h4000_0000, 40, FILL_LINES, 1'b0, 1'b1);

        $display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // hang guard scaled to the number of beats in the run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout in %s: the DMA did not finish its bursts in %0d cycles", test_name,
                 WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
